// ==== project.f ====
source/rv_core_pkg.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core_top.sv
testbench/rv_core_checker.sv
testbench/tb_rv_core.sv

// ==== Makefile ====
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== testbench/tb_rv_core.sv ====
// Random RV32I stream with random back-pressure on both ends
// The DUT register file has no reset, so all 31 registers are loaded first
`timescale 1ns/1ns

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int NUM_INIT   = 62;    // LUI + ADDI for x1..x31
    localparam int NUM_RANDOM = 2000;
    localparam int NUM_TOTAL  = NUM_INIT + NUM_RANDOM;
    localparam int MAX_CYCLES = 4 * NUM_TOTAL + 100;  // Each stream idles a quarter of the time

    logic        clk;
    logic        rstz;
    fetch_t      fetch;
    logic        fetch_vld;
    logic        fetch_rdy;
    ex_result_t  result;
    logic        result_vld;
    logic        result_rdy;
    int          mismatches;
    int          other_errors;
    int          retired;
    int          timeouts;
    int          sent;
    int          cycles;
    integer      seed;
    logic [31:0] pc;
    logic [31:0] rnd;
    logic [31:0] prog [NUM_TOTAL];

    rv_core_top i_dut (
        .clk        (clk),
        .rstz       (rstz),
        .fetch      (fetch),
        .fetch_vld  (fetch_vld),
        .fetch_rdy  (fetch_rdy),
        .result     (result),
        .result_vld (result_vld),
        .result_rdy (result_rdy)
    );

    rv_core_checker i_checker (
        .clk          (clk),
        .rstz         (rstz),
        .fetch        (fetch),
        .fetch_vld    (fetch_vld),
        .fetch_rdy    (fetch_rdy),
        .result       (result),
        .result_vld   (result_vld),
        .result_rdy   (result_rdy),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .retired      (retired)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // ------------------------------------------------------------------------
    // Instruction generator, about 1 in 8 keeps raw funct bits
    task automatic random_instr(input logic [4:0] prev_rd, output logic [31:0] word);
        logic [31:0] raw;
        logic [31:0] pick;
        logic        fix;
        raw  = $random(seed);
        pick = $random(seed);
        fix  = pick[8:6] != 3'b000;
        word = raw;
        if (pick[5:4] == 2'b00) begin
            word[19:15] = prev_rd;  // Back-to-back dependency
        end
        case (pick[3:0])
            4'd0: word[6:0] = {INSTR_LUI, 2'b11};
            4'd1: word[6:0] = {INSTR_AUIPC, 2'b11};
            4'd2: word[6:0] = {INSTR_JAL, 2'b11};
            4'd3: begin
                word[6:0] = {INSTR_JALR, 2'b11};
                if (fix) word[14:12] = 3'b000;
            end
            4'd4, 4'd5: begin
                word[6:0] = {INSTR_BR, 2'b11};
                if (fix && word[14:13] == 2'b01) word[14] = 1'b1;  // No 010/011
            end
            4'd6: begin
                word[6:0] = {INSTR_LOAD, 2'b11};
                if (fix && word[14:12] == 3'b011) word[14:12] = 3'b010;
                if (fix && word[14:13] == 2'b11) word[13] = 1'b0;   // 11x to LBU / LHU
            end
            4'd7: begin
                word[6:0] = {INSTR_STORE, 2'b11};
                if (fix) word[14] = 1'b0;
                if (fix && word[13:12] == 2'b11) word[12] = 1'b0;
            end
            4'd8, 4'd9, 4'd10: begin
                word[6:0] = {INSTR_OPIMM, 2'b11};
                if (fix && word[13:12] == 2'b01) word[31:25] = {1'b0, word[14] & raw[30], 5'd0};
            end
            4'd11, 4'd12, 4'd13: begin
                word[6:0] = {INSTR_OP, 2'b11};
                if (fix) begin
                    word[31:25] = {1'b0, (word[14:12] == 3'b000 || word[14:12] == 3'b101)
                                   && raw[30], 5'd0};
                end
            end
            4'd14: word = raw;  // Mostly unknown opcodes
            default: word[6:0] = {INSTR_OP, raw[1:0] == 2'b11 ? 2'b01 : raw[1:0]};
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Program, reset, then the streaming loop
    initial begin
        seed       = 32'h06cc_b587;
        rstz       = 1'b0;
        fetch      = '0;
        fetch_vld  = 1'b0;
        result_rdy = 1'b0;
        pc         = 32'h0000_1000;
        sent       = 0;
        cycles     = 0;
        timeouts   = 0;
        for (int i = 1; i < 32; i++) begin
            rnd = $random(seed);
            prog[2*i-2] = {rnd[31:12], 5'(i), INSTR_LUI, 2'b11};
            prog[2*i-1] = {rnd[11:0], 5'(i), 3'b000, 5'(i), INSTR_OPIMM, 2'b11};
        end
        for (int k = NUM_INIT; k < NUM_TOTAL; k++) begin
            random_instr(prog[k-1][11:7], prog[k]);
        end

        repeat (2) @(posedge clk);
        rstz <= 1'b1;

        while (retired < NUM_TOTAL && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
            rnd = $random(seed);
            result_rdy <= rnd[1:0] != 2'b00;
            if (!fetch_vld || fetch_rdy) begin  // Free to change only after a transfer
                if (sent < NUM_TOTAL && rnd[3:2] != 2'b00) begin
                    fetch     <= {pc, prog[sent]};
                    fetch_vld <= 1'b1;
                    sent++;
                    pc = pc + 32'd4;
                end else begin
                    fetch_vld <= 1'b0;
                end
            end
        end

        if (cycles >= MAX_CYCLES) begin
            timeouts = 1;
            $display("timeout: only %0d of %0d results after %0d cycles",
                     retired, NUM_TOTAL, cycles);
        end
        repeat (4) begin
            @(posedge clk);
            result_rdy <= 1'b1;  // Flush out any extra result
        end

        $display("errors: %0d mismatches, %0d other, %0d timeout",
                 mismatches, other_errors, timeouts);
        if (mismatches + other_errors + timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== testbench/rv_core_checker.sv ====
// Reference model of the RV32I datapath, compares result records in order
// Illegal encodings are checked for pc and the illegal flag only
`timescale 1ns/1ns

module rv_core_checker (
    input  logic                    clk,
    input  logic                    rstz,
    input  rv_core_pkg::fetch_t     fetch,
    input  logic                    fetch_vld,
    input  logic                    fetch_rdy,
    input  rv_core_pkg::ex_result_t result,
    input  logic                    result_vld,
    input  logic                    result_rdy,
    output int                      mismatches,
    output int                      other_errors,
    output int                      retired
);
    import rv_core_pkg::*;

    typedef struct packed {
        ex_result_t rec;
        logic       full;  // Legal op, every field compared
        logic       dest;  // result2 defined (jump, branch, store)
    } expect_t;

    bit [31:0] arch [32];  // Architectural registers, x0 never written
    expect_t   pending [$];
    expect_t   next_exp;

    // ------------------------------------------------------------------------
    // Sequential RV32I semantics, one instruction per call
    task automatic predict_record(input fetch_t f, output expect_t e);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic        is_op;
        logic        ok;
        logic        rd_op;
        w     = f.ir;
        a     = arch[w[19:15]];
        b     = arch[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'd0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        is_op = w[6:2] == INSTR_OP;
        y     = is_op ? b : imm_i;
        e     = '0;
        e.rec.pc = f.pc;
        ok    = 1'b1;
        rd_op = 1'b0;
        case (w[6:2])
            INSTR_LUI, INSTR_AUIPC: begin
                e.rec.result1 = (w[6:2] == INSTR_LUI) ? imm_u : f.pc + imm_u;
                rd_op = 1'b1;
            end
            INSTR_JAL, INSTR_JALR: begin
                e.rec.result1 = f.pc + 32'd4;  // Link value
                e.rec.result2 = (w[6:2] == INSTR_JAL) ? f.pc + imm_j
                                                      : (a + imm_i) & ~32'd1;
                e.rec.taken   = 1'b1;
                e.rec.branch  = 1'b1;
                e.dest = 1'b1;
                rd_op  = 1'b1;
                ok     = w[6:2] == INSTR_JAL || w[14:12] == 3'b000;
            end
            INSTR_BR: begin
                case (w[14:12])
                    3'b000:  e.rec.taken = a == b;
                    3'b001:  e.rec.taken = a != b;
                    3'b100:  e.rec.taken = $signed(a) < $signed(b);
                    3'b101:  e.rec.taken = $signed(a) >= $signed(b);
                    3'b110:  e.rec.taken = a < b;
                    3'b111:  e.rec.taken = a >= b;
                    default: ok = 1'b0;
                endcase
                e.rec.result1     = {31'd0, e.rec.taken};
                e.rec.result2     = f.pc + imm_b;
                e.rec.branch_cond = 1'b1;
                e.dest = 1'b1;
            end
            INSTR_LOAD: begin
                e.rec.result1 = a + imm_i;
                e.rec.ld = 1'b1;
                rd_op = 1'b1;
                ok = w[14:12] != 3'b011 && w[14:12] != 3'b110 && w[14:12] != 3'b111;
            end
            INSTR_STORE: begin
                e.rec.result1 = a + imm_s;
                e.rec.result2 = b;  // Store data
                e.rec.st = 1'b1;
                e.dest = 1'b1;
                ok = w[14:12] < 3'd3;
            end
            INSTR_OP, INSTR_OPIMM: begin
                rd_op = 1'b1;
                case (w[14:12])
                    3'b000: begin
                        e.rec.result1 = (is_op && w[30]) ? a - y : a + y;
                        ok = !is_op || w[31:25] == 7'd0 || w[31:25] == 7'd32;
                    end
                    3'b001: begin
                        e.rec.result1 = a << y[4:0];
                        ok = w[31:25] == 7'd0;
                    end
                    3'b101: begin
                        if (w[30]) begin
                            e.rec.result1 = $signed(a) >>> y[4:0];
                        end else begin
                            e.rec.result1 = a >> y[4:0];
                        end
                        ok = w[31:25] == 7'd0 || w[31:25] == 7'd32;
                    end
                    3'b010: e.rec.result1 = {31'd0, $signed(a) < $signed(y)};
                    3'b011: e.rec.result1 = {31'd0, a < y};
                    3'b100: e.rec.result1 = a ^ y;
                    3'b110: e.rec.result1 = a | y;
                    default: e.rec.result1 = a & y;
                endcase
                if (is_op && w[31:25] != 7'd0 && w[14:12] != 3'b000 && w[14:12] != 3'b101) begin
                    ok = 1'b0;
                end
            end
            default: ok = 1'b0;
        endcase
        if (w[1:0] != 2'b11) ok = 1'b0;
        if (e.rec.ld || e.rec.st) begin
            e.rec.data_size = w[13:12];
            e.rec.data_uns  = w[14];
        end
        if (rd_op && w[11:7] != 5'd0) begin
            e.rec.rd       = w[11:7];
            e.rec.rd_write = 1'b1;
        end
        e.rec.illegal = !ok;
        e.full        = ok;
        if (ok && e.rec.rd_write && !e.rec.ld) begin
            arch[w[11:7]] = e.rec.result1;  // pc + 4 for jumps
        end
    endtask

    task automatic compare_record(input expect_t e, input ex_result_t got);
        ex_result_t seen;
        seen = got;
        if (!e.dest) seen.result2 = e.rec.result2;
        if (!e.full) begin
            seen         = e.rec;
            seen.pc      = got.pc;
            seen.illegal = got.illegal;
        end
        if (seen !== e.rec) begin
            mismatches <= mismatches + 1;
            $display("mismatch at %0t: pc %08h, expected record %h, got %h",
                     $time, e.rec.pc, e.rec, got);
        end
    endtask

    // ------------------------------------------------------------------------
    // Both streams sampled before the edge updates them
    always @(posedge clk) begin
        if (rstz) begin
            if (fetch_vld && fetch_rdy) begin
                predict_record(fetch, next_exp);
                pending.push_back(next_exp);
            end
            if (result_vld && result_rdy) begin
                retired <= retired + 1;
                if (pending.size() == 0) begin
                    other_errors <= other_errors + 1;
                    $display("result for pc %08h at %0t with no instruction outstanding",
                             result.pc, $time);
                end else begin
                    compare_record(pending.pop_front(), result);
                end
            end
        end
    end

endmodule

// ==== source/rv_core_top.sv ====
// RV32I integer datapath, fetch stream in, result stream out
// Two-stage pipe, no memory access and no pc redirection
`timescale 1ns/1ns

module rv_core_top (
    input  logic                    clk,
    input  logic                    rstz,
    input  rv_core_pkg::fetch_t     fetch,
    input  logic                    fetch_vld,
    output logic                    fetch_rdy,
    output rv_core_pkg::ex_result_t result,
    output logic                    result_vld,
    input  logic                    result_rdy
);
    import rv_core_pkg::*;

    decode_t    dec;
    logic       dec_vld;
    logic       dec_rdy;
    reg_write_t regwr;  // Execute back into decode

    rv_decode i_decode (
        .clk          (clk),
        .rstz         (rstz),
        .fetch        (fetch),
        .pipe_in_vld  (fetch_vld),
        .pipe_in_rdy  (fetch_rdy),
        .decode       (dec),
        .pipe_out_vld (dec_vld),
        .pipe_out_rdy (dec_rdy),
        .regwr        (regwr)
    );

    rv_execute i_execute (
        .clk        (clk),
        .rstz       (rstz),
        .decode     (dec),
        .dec_vld    (dec_vld),
        .dec_rdy    (dec_rdy),
        .regwr      (regwr),
        .result     (result),
        .result_vld (result_vld),
        .result_rdy (result_rdy)
    );

endmodule

// ==== source/rv_execute.sv ====
// Execute stage with one-entry result register
// Loads and illegal ops never write a register
`timescale 1ns/1ns

module rv_execute (
    input  logic                    clk,
    input  logic                    rstz,
    input  rv_core_pkg::decode_t    decode,
    input  logic                    dec_vld,
    output logic                    dec_rdy,
    output rv_core_pkg::reg_write_t regwr,
    output rv_core_pkg::ex_result_t result,
    output logic                    result_vld,
    input  logic                    result_rdy
);
    import rv_core_pkg::*;

    logic        capture;
    logic [31:0] alu_out;
    logic [31:0] sum2;
    logic [31:0] target;

    rv_alu i_alu (
        .ctrl   (decode.ex),
        .op1    (decode.op1),
        .op2    (decode.op2),
        .result (alu_out)
    );

    assign sum2    = decode.op3 + decode.op4;
    assign target  = {sum2[31:1], sum2[0] & ~decode.ex.align};  // JALR alignment
    assign dec_rdy = ~result_vld | result_rdy;
    assign capture = dec_vld & dec_rdy;

    // Writeback lands on the capture edge, decode forwards it meanwhile
    assign regwr.en   = capture && decode.rd_write && !decode.ld && !decode.illegal;
    assign regwr.sel  = decode.rd;
    assign regwr.data = decode.branch ? decode.pc + FOUR : alu_out;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            result_vld <= 1'b0;
        end else if (capture) begin
            result_vld <= 1'b1;
        end else if (result_rdy) begin
            result_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result.pc          <= decode.pc;
            result.result1     <= alu_out;
            result.result2     <= target;
            result.rd          <= decode.rd;
            result.rd_write    <= decode.rd_write;
            result.taken       <= decode.branch_cond ? alu_out[0] : decode.branch;
            result.branch      <= decode.branch;
            result.branch_cond <= decode.branch_cond;
            result.ld          <= decode.ld;
            result.st          <= decode.st;
            result.data_size   <= decode.data_size;
            result.data_uns    <= decode.data_uns;
            result.illegal     <= decode.illegal;
        end
    end

    a_vld_known : assert property (
        @(posedge clk) disable iff (!rstz)
        !$isunknown(result_vld)
    ) else $error("result_vld unknown");

endmodule

// ==== source/rv_decode.sv ====
// RV32I decoder with register file and one-entry output pipe register
// regwr is the same-cycle writeback from execute, forwarded into reads
`timescale 1ns/1ns

module rv_decode (
    input  logic                    clk,
    input  logic                    rstz,
    input  rv_core_pkg::fetch_t     fetch,
    input  logic                    pipe_in_vld,
    output logic                    pipe_in_rdy,
    output rv_core_pkg::decode_t    decode,
    output logic                    pipe_out_vld,
    input  logic                    pipe_out_rdy,
    input  rv_core_pkg::reg_write_t regwr
);
    import rv_core_pkg::*;

    instr_t      ir;
    logic [4:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        is_imm;
    logic        valid;
    logic        rs1_en;
    logic        rs2_en;
    logic        rd_en;
    logic [31:0] rf_rs1;
    logic [31:0] rf_rs2;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    ex_ctrl_t    ctrl;
    decode_t     nxt;

    assign ir     = fetch.ir;
    assign op     = ir.r.opcode[6:2];
    assign f3     = ir.r.funct3;
    assign f7     = ir.r.funct7;
    assign is_imm = op == INSTR_OPIMM;

    // ------------------------------------------------------------------------
    // Register reads with forwarding

    rv_regfile i_regfile (
        .clk      (clk),
        .rstz     (rstz),
        .rs1      (ir.r.rs1),
        .rs2      (ir.r.rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .wr       (regwr)
    );

    assign rs1_en = op == INSTR_OPIMM || op == INSTR_OP || op == INSTR_JALR
                 || op == INSTR_BR || op == INSTR_LOAD || op == INSTR_STORE;
    assign rs2_en = op == INSTR_OP || op == INSTR_BR || op == INSTR_STORE;
    assign rd_en  = ir.r.rd != 5'd0
                 && (op == INSTR_LUI || op == INSTR_AUIPC || op == INSTR_JAL
                 || op == INSTR_JALR || op == INSTR_OPIMM || op == INSTR_OP
                 || op == INSTR_LOAD);

    always_comb begin
        rs1_val = ZERO;  // Unused or x0
        rs2_val = ZERO;
        if (rs1_en && ir.r.rs1 != 5'd0) begin
            rs1_val = (regwr.en && regwr.sel == ir.r.rs1) ? regwr.data : rf_rs1;
        end
        if (rs2_en && ir.r.rs2 != 5'd0) begin
            rs2_val = (regwr.en && regwr.sel == ir.r.rs2) ? regwr.data : rf_rs2;
        end
    end

    // Immediate per format view
    always_comb begin
        case (op)
            INSTR_LUI, INSTR_AUIPC: imm = {ir.u.imm_31_12, 12'd0};
            INSTR_JAL: imm = {{12{ir.j.imm_20}}, ir.j.imm_19_12, ir.j.imm_11,
                              ir.j.imm_10_1, 1'b0};
            INSTR_BR: imm = {{20{ir.b.imm_12}}, ir.b.imm_11, ir.b.imm_10_5,
                             ir.b.imm_4_1, 1'b0};
            INSTR_STORE: imm = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
            default: imm = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};  // I type
        endcase
    end

    // ------------------------------------------------------------------------
    // Execute controls and validity

    always_comb begin
        ctrl     = '0;
        ctrl.sel = ALU_ADDER;  // Plain add by default
        valid    = 1'b0;
        case (op)
            INSTR_LUI, INSTR_AUIPC, INSTR_JAL: valid = 1'b1;
            INSTR_JALR: begin
                ctrl.align = 1'b1;
                valid      = f3 == 3'b000;
            end
            INSTR_BR: begin
                ctrl.sel = ALU_COMP;
                ctrl.eq  = ~f3[2];  // BEQ / BNE
                ctrl.cin = f3[2];   // Less-than forms subtract
                ctrl.uns = f3[1];
                ctrl.inv = f3[0];
                valid    = f3[2:1] != 2'b01;
            end
            INSTR_LOAD:  valid = f3[1:0] != 2'b11 && f3 != 3'b110;
            INSTR_STORE: valid = !f3[2] && f3[1:0] != 2'b11;
            INSTR_OP, INSTR_OPIMM: begin
                case (f3)
                    3'b000: ctrl.cin = !is_imm && f7[5];  // SUB
                    3'b001: begin                          // SLL via reversal
                        ctrl.rev = 1'b1;
                        ctrl.uns = 1'b1;
                        ctrl.sel = ALU_SHIFT;
                    end
                    3'b010: begin
                        ctrl.cin = 1'b1;
                        ctrl.sel = ALU_COMP;
                    end
                    3'b011: begin
                        ctrl.cin = 1'b1;
                        ctrl.uns = 1'b1;
                        ctrl.sel = ALU_COMP;
                    end
                    3'b100: ctrl.sel = ALU_XOR;
                    3'b101: begin                          // SRL / SRA
                        ctrl.uns = ~f7[5];
                        ctrl.sel = ALU_SHIFT;
                    end
                    3'b110: ctrl.sel = ALU_OR;
                    default: ctrl.sel = ALU_AND;
                endcase
                // funct7 only qualifies register forms and immediate shifts
                valid = (is_imm && f3[1:0] != 2'b01) || f7 == 7'd0
                     || (f7 == 7'd32 && (f3 == 3'b101 || (f3 == 3'b000 && !is_imm)));
            end
            default: valid = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Operands and writeback controls

    always_comb begin
        nxt.op1 = fetch.pc;
        nxt.op2 = FOUR;      // pc + 4 link by default
        nxt.op3 = fetch.pc;
        nxt.op4 = ZERO;
        case (op)
            INSTR_LUI: begin
                nxt.op1 = ZERO;
                nxt.op2 = imm;
            end
            INSTR_AUIPC: nxt.op2 = imm;
            INSTR_JAL:   nxt.op4 = imm;
            INSTR_JALR: begin
                nxt.op3 = rs1_val;
                nxt.op4 = imm;
            end
            INSTR_BR: begin
                nxt.op1 = rs1_val;
                nxt.op2 = rs2_val;
                nxt.op4 = imm;     // Target pc + imm
            end
            INSTR_STORE: begin
                nxt.op1 = rs1_val;
                nxt.op2 = imm;
                nxt.op3 = ZERO;
                nxt.op4 = rs2_val; // Store data
            end
            INSTR_OP: begin
                nxt.op1 = rs1_val;
                nxt.op2 = rs2_val;
            end
            INSTR_LOAD, INSTR_OPIMM: begin
                nxt.op1 = rs1_val;
                nxt.op2 = imm;
            end
            default: nxt.op4 = ZERO;
        endcase
        nxt.pc          = fetch.pc;
        nxt.ex          = ctrl;
        nxt.rd          = rd_en ? ir.r.rd : 5'd0;
        nxt.rd_write    = rd_en;
        nxt.branch      = op == INSTR_JAL || op == INSTR_JALR;
        nxt.branch_cond = op == INSTR_BR;
        nxt.ld          = op == INSTR_LOAD;
        nxt.st          = op == INSTR_STORE;
        nxt.data_size   = (nxt.ld || nxt.st) ? f3[1:0] : 2'b00;
        nxt.data_uns    = (nxt.ld || nxt.st) && f3[2];
        nxt.illegal     = !valid || ir.r.opcode[1:0] != 2'b11;
    end

    // ------------------------------------------------------------------------
    // Output pipe register

    assign pipe_in_rdy = ~pipe_out_vld | pipe_out_rdy;  // Empty or draining

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            pipe_out_vld <= 1'b0;
        end else if (pipe_in_vld && pipe_in_rdy) begin
            pipe_out_vld <= 1'b1;
        end else if (pipe_out_rdy) begin
            pipe_out_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pipe_in_vld && pipe_in_rdy) begin
            decode <= nxt;
        end
    end

    a_decode_hold : assert property (
        @(posedge clk) disable iff (!rstz)
        pipe_out_vld && !pipe_out_rdy |=> $stable(decode)
    ) else $error("decode changed while stalled");

endmodule

// ==== source/rv_alu.sv ====
// Shared add/compare/shift/logic unit, purely combinational
// Left shift reuses the right shifter through bit reversal
`timescale 1ns/1ns

module rv_alu (
    input  rv_core_pkg::ex_ctrl_t ctrl,
    input  logic [31:0]           op1,
    input  logic [31:0]           op2,
    output logic [31:0]           result
);
    import rv_core_pkg::*;

    logic [32:0] sum;
    logic        lt;
    logic        comp;
    logic        fill;
    logic [31:0] sh_in;
    logic [31:0] sh_raw;
    logic [31:0] sh_out;

    // ------------------------------------------------------------------------
    // Adder, subtracts when cin is set
    assign sum = {1'b0, op1} + {1'b0, op2 ^ {32{ctrl.cin}}} + 33'(ctrl.cin);

    // Carry out of op1 - op2 means op1 >= op2 unsigned
    always_comb begin
        if (ctrl.uns) begin
            lt = ~sum[32];
        end else if (op1[31] != op2[31]) begin
            lt = op1[31];  // Signs differ, negative one is smaller
        end else begin
            lt = sum[31];
        end
    end

    assign comp = (ctrl.eq ? (op1 == op2) : lt) ^ ctrl.inv;

    // ------------------------------------------------------------------------
    // Shifter
    assign sh_in  = ctrl.rev ? {<<{op1}} : op1;
    assign fill   = ~ctrl.uns & sh_in[31];  // Arithmetic fill for SRA
    assign sh_raw = 32'($signed({fill, sh_in}) >>> op2[4:0]);
    assign sh_out = ctrl.rev ? {<<{sh_raw}} : sh_raw;

    always_comb begin
        case (ctrl.sel)
            ALU_COMP:  result = {31'd0, comp};
            ALU_XOR:   result = op1 ^ op2;
            ALU_OR:    result = op1 | op2;
            ALU_AND:   result = op1 & op2;
            ALU_SHIFT: result = sh_out;
            default:   result = sum[31:0];  // ALU_ADDER
        endcase
    end

endmodule

// ==== source/rv_regfile.sv ====
// Flip-flop register file, combinational reads, write on rising clk
// x0 is not stored and always reads zero
`timescale 1ns/1ns

module rv_regfile (
    input  logic                    clk,
    input  logic                    rstz,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [31:0]             rs1_data,
    output logic [31:0]             rs2_data,
    input  rv_core_pkg::reg_write_t wr
);

    logic [31:0] regs [1:31];  // x1..x31 only

    always_ff @(posedge clk) begin
        if (wr.en && wr.sel != 5'd0) begin
            regs[wr.sel] <= wr.data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    // Decode never flags rd_write for x0, so execute must not issue one
    a_no_x0_write : assert property (
        @(posedge clk) disable iff (!rstz)
        wr.en |-> wr.sel != 5'd0
    ) else $error("register write to x0");

endmodule

// ==== source/rv_core_pkg.sv ====
// Shared encodings and stage records for the RV32I integer datapath
// Major opcodes hold instruction bits 6:2 only, bits 1:0 are checked in decode
package rv_core_pkg;

    // ------------------------------------------------------------------------
    // Major opcodes
    localparam logic [4:0] INSTR_LUI   = 5'b01101;
    localparam logic [4:0] INSTR_AUIPC = 5'b00101;
    localparam logic [4:0] INSTR_JAL   = 5'b11011;
    localparam logic [4:0] INSTR_JALR  = 5'b11001;
    localparam logic [4:0] INSTR_BR    = 5'b11000;
    localparam logic [4:0] INSTR_LOAD  = 5'b00000;
    localparam logic [4:0] INSTR_STORE = 5'b01000;
    localparam logic [4:0] INSTR_OPIMM = 5'b00100;
    localparam logic [4:0] INSTR_OP    = 5'b01100;

    // ALU result select
    localparam logic [2:0] ALU_ADDER = 3'd0;
    localparam logic [2:0] ALU_COMP  = 3'd1;
    localparam logic [2:0] ALU_XOR   = 3'd2;
    localparam logic [2:0] ALU_OR    = 3'd3;
    localparam logic [2:0] ALU_AND   = 3'd4;
    localparam logic [2:0] ALU_SHIFT = 3'd5;

    localparam logic [31:0] FOUR = 32'd4;
    localparam logic [31:0] ZERO = 32'd0;

    // ------------------------------------------------------------------------
    // Instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_t;

    // ------------------------------------------------------------------------
    // Stage records
    typedef struct packed {
        logic [31:0] pc;
        instr_t      ir;
    } fetch_t;

    typedef struct packed {
        logic       cin;    // Subtract / compare
        logic       rev;    // Bit reverse around shifter
        logic       uns;    // Unsigned compare, logical shift
        logic       eq;     // Equality instead of less-than
        logic       inv;    // Invert compare
        logic       align;  // Clear bit 0 of result2
        logic [2:0] sel;
    } ex_ctrl_t;

    typedef struct packed {
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] op3;
        logic [31:0] op4;
        logic [31:0] pc;
        ex_ctrl_t    ex;
        logic [4:0]  rd;
        logic        rd_write;
        logic        branch;       // JAL / JALR
        logic        branch_cond;  // Conditional branch
        logic        ld;
        logic        st;
        logic [1:0]  data_size;
        logic        data_uns;
        logic        illegal;
    } decode_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  sel;
        logic [31:0] data;
    } reg_write_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result1;  // ALU out, address or condition
        logic [31:0] result2;  // Target or store data
        logic [4:0]  rd;
        logic        rd_write;
        logic        taken;
        logic        branch;
        logic        branch_cond;
        logic        ld;
        logic        st;
        logic [1:0]  data_size;
        logic        data_uns;
        logic        illegal;
    } ex_result_t;

endpackage
